//--- bench/hbus_input.dat
# name op addr wdata sel delay expected, all hex except name; op 0 write, 1 read, 2 unmapped
# reads take wdata as the device's four link bytes, first byte on top; delay ffff = no answer
lat_rst        1 30c00000 00000000 f 0000 00000036
tim_rst        1 30c00004 00000000 f 0000 00000044
tcsh_rst       1 30c00008 00000000 f 0000 00000004
trmax_rst      1 30c0000c 00000000 f 0000 00000014
stat_rst       1 30c00010 00000000 f 0000 00000000
tcsh_wr        0 30c00008 0000003a f 0000 00000000
tcsh_rd        1 30c00008 00000000 f 0000 0000000a
tcsh_wr_nosel  0 30c00008 00000007 e 0000 00000000
tcsh_rd_keep   1 30c00008 00000000 f 0000 0000000a
trmax_wr       0 30c0000c 000000ff 1 0000 00000000
trmax_rd       1 30c0000c 00000000 f 0000 0000001f
tim_wr         0 30c00004 00000023 1 0000 00000000
tim_rd         1 30c00004 00000000 f 0000 00000023
stat_wr        0 30c00010 000000ff f 0000 00000000
stat_rd        1 30c00010 00000000 f 0000 00000000
ram_wr         0 30001234 a1b2c3d4 5 0000 a1b2c3d4
reg_wr         0 30800010 5a5a0f0f f 0000 5a5a0f0f
ram_rd         1 30000100 11223344 f 001c 33441122
reg_rd         1 30800002 deadbeef f 001c beefdead
stat_rd_ok     1 30c00010 00000000 f 0000 00000000
ram_rd_tmo     1 30000200 00000000 f ffff 00000000
stat_rd_tmo    1 30c00010 00000000 f 0000 00000001
ram_rd_good    1 30000204 01020304 f 001e 03040102
stat_rd_clr    1 30c00010 00000000 f 0000 00000000
unmapped       2 31000000 00000000 f 0000 00000000

//--- bench/tb_wb_hbus.sv
`timescale 1ns/1ps

module tb_wb_hbus import hbus_pkg::*; ();

	localparam int ACK_LIMIT     = 200;
	localparam int UNMAPPED_WAIT = 40;

	logic        wb_clk_i;
	logic        arst_n_i;
	logic        wbs_stb_i;
	logic        wbs_cyc_i;
	logic        wbs_we_i;
	logic [3:0]  wbs_sel_i;
	logic [31:0] wbs_dat_i;
	logic [31:0] wbs_adr_i;
	logic        wbs_ack_o;
	logic [31:0] wbs_dat_o;
	logic        hb_rstn_o;
	logic        hb_csn_o;
	logic        hb_clk_o;
	logic        hb_clkn_o;
	logic        hb_rwds_o;
	logic        hb_rwds_oe_o;
	logic [7:0]  hb_dq_o;
	logic        hb_dq_oe_o;
	logic        hb_rwds_i;
	logic [7:0]  hb_dq_i;

	// what the device model saw on the link
	hb_ca_u      cap_ca;
	logic [31:0] cap_data;
	logic [3:0]  cap_mask;
	int          cap_cnt;
	// read reply for the current step
	logic [31:0] model_bytes;
	logic [15:0] model_delay;
	string       step_name;

	wb_hbus_top u_dut (.*);

	initial wb_clk_i = 1'b0;
	always #4 wb_clk_i = ~wb_clk_i;

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("mismatch %0s: expected %08h actual %08h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_ca(input string name, input hb_ca_u exp, input hb_ca_u act);
		if (act !== exp) begin
			$display("mismatch %0s: expected %012h actual %012h", name, exp.bytes, act.bytes);
			abort_run();
		end
	endtask

	task automatic check_mask(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			$display("mismatch %0s: expected %01h actual %01h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %0s: expected %0b actual %0b", name, exp, act);
			abort_run();
		end
	endtask

	// CA word as the device should decode it, address in 16-bit words
	function automatic hb_ca_u expected_ca(input logic [31:0] addr, input logic rd);
		hb_ca_u      ca;
		logic [31:0] wa;
		logic        reg_space;
		reg_space = ((addr & REG_CSR_MASK) == REG_BASE);
		wa = (reg_space ? addr - REG_BASE : addr - BASE_ADDR) >> 1;
		ca.f.rd        = rd;
		ca.f.reg_space = reg_space;
		ca.f.linear    = 1'b1;
		ca.f.addr_hi   = wa[31:3];
		ca.f.rsvd      = '0;
		ca.f.addr_lo   = wa[2:0];
		return ca;
	endfunction

	task automatic bus_cycle(input string name, input logic we, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge wb_clk_i);
		wbs_stb_i <= 1'b1;
		wbs_cyc_i <= 1'b1;
		wbs_we_i  <= we;
		wbs_adr_i <= addr;
		wbs_dat_i <= wdata;
		wbs_sel_i <= sel;
		do begin
			@(negedge wb_clk_i);
			waited++;
		end while (!wbs_ack_o && waited < ACK_LIMIT);
		if (!wbs_ack_o) begin
			$display("%0s: no acknowledge within %0d cycles", name, ACK_LIMIT);
			abort_run();
		end
		rdata = wbs_dat_o;
		@(posedge wb_clk_i);
		wbs_stb_i <= 1'b0;
		wbs_cyc_i <= 1'b0;
		wbs_we_i  <= 1'b0;
	endtask

	task automatic expect_no_ack(input string name, input logic [31:0] addr);
		@(posedge wb_clk_i);
		wbs_stb_i <= 1'b1;
		wbs_cyc_i <= 1'b1;
		wbs_we_i  <= 1'b0;
		wbs_adr_i <= addr;
		for (int i = 0; i < UNMAPPED_WAIT; i++) begin
			@(negedge wb_clk_i);
			if (wbs_ack_o || !hb_csn_o) begin
				$display("%0s: the unmapped access was answered", name);
				abort_run();
			end
		end
		@(posedge wb_clk_i);
		wbs_stb_i <= 1'b0;
		wbs_cyc_i <= 1'b0;
	endtask

	task automatic run_step(input string name, input logic [3:0] op, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] sel, input logic [15:0] dly,
		input logic [31:0] expv);
		logic [31:0] wdata;
		logic [31:0] rnd;
		logic [31:0] rdata;
		logic        hb_side;
		hb_side = ((addr & RAM_MASK) == BASE_ADDR) || ((addr & REG_CSR_MASK) == REG_BASE);
		step_name = name;
		rnd     = $urandom();
		wdata   = data;
		// CSRs are one byte at most
		if ((addr & REG_CSR_MASK) == CSR_BASE)
			wdata = {rnd[31:8], data[7:0]};
		model_bytes = data;
		model_delay = dly;
		if (op == 4'h2) begin
			expect_no_ack(name, addr);
		end else if (op == 4'h0) begin
			bus_cycle(name, 1'b1, addr, wdata, sel, rdata);
			check_word(name, 32'h0, rdata);
			if (hb_side) begin
				check_word({name, " bytes"}, 32'(CA_BYTES + DATA_BYTES), 32'(cap_cnt));
				check_ca(name, expected_ca(addr, 1'b0), cap_ca);
				check_word(name, expv, cap_data);
				check_mask(name, ~sel, cap_mask);
			end
		end else begin
			bus_cycle(name, 1'b0, addr, 32'h0, sel, rdata);
			check_word(name, expv, rdata);
			if (hb_side) begin
				check_word({name, " bytes"}, 32'(CA_BYTES), 32'(cap_cnt));
				check_ca(name, expected_ca(addr, 1'b1), cap_ca);
			end
		end
	endtask

	task automatic answer_read();
		repeat (model_delay) @(posedge wb_clk_i);
		for (int i = 0; i < DATA_BYTES; i++) begin
			@(posedge wb_clk_i);
			hb_rwds_i <= 1'b1;
			hb_dq_i   <= model_bytes[31 - 8*i -: 8];
		end
		@(posedge wb_clk_i);
		hb_rwds_i <= 1'b0;
		hb_dq_i   <= 8'h00;
	endtask

	// HyperBus device model, one byte per clock edge while selected
	initial begin : device_model
		logic last_clk;
		logic last_csn;
		logic answered;
		int   lane;
		hb_rwds_i = 1'b0;
		hb_dq_i   = 8'h00;
		last_clk  = 1'b0;
		last_csn  = 1'b1;
		answered  = 1'b0;
		cap_cnt   = 0;
		forever begin
			@(negedge wb_clk_i);
			check_bit({step_name, " clkn"}, ~hb_clk_o, hb_clkn_o);
			if (!hb_csn_o && last_csn) begin
				cap_cnt  = 0;
				answered = 1'b0;
			end
			if (!hb_csn_o && (hb_clk_o != last_clk)) begin
				check_bit({step_name, " dq_oe"}, 1'b1, hb_dq_oe_o);
				if (cap_cnt < CA_BYTES) begin
					cap_ca.bytes[CA_BYTES - 1 - cap_cnt] = hb_dq_o;
				end else if (cap_cnt < CA_BYTES + DATA_BYTES) begin
					check_bit({step_name, " rwds_oe"}, 1'b1, hb_rwds_oe_o);
					// link order 15:8, 7:0, 31:24, 23:16
					lane = (cap_cnt - CA_BYTES) ^ 1;
					cap_data[lane*8 +: 8] = hb_dq_o;
					cap_mask[lane] = hb_rwds_o;
				end
				cap_cnt++;
			end
			last_clk = hb_clk_o;
			last_csn = hb_csn_o;
			if (!hb_csn_o && cap_cnt == CA_BYTES && cap_ca.f.rd && !answered &&
				model_delay != 16'hffff) begin
				answered = 1'b1;
				answer_read();
			end
		end
	end

	initial begin : main_seq
		int          fd;
		int          steps;
		int          n;
		string       line;
		string       name;
		logic [3:0]  op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  sel;
		logic [15:0] dly;
		logic [31:0] expv;
		void'($urandom(32'h7ecf));
		arst_n_i    = 1'b0;
		wbs_stb_i   = 1'b0;
		wbs_cyc_i   = 1'b0;
		wbs_we_i    = 1'b0;
		wbs_sel_i   = 4'h0;
		wbs_dat_i   = 32'h0;
		wbs_adr_i   = 32'h0;
		model_bytes = 32'h0;
		model_delay = 16'h0;
		step_name   = "reset";
		steps       = 0;
		repeat (9) @(posedge wb_clk_i);
		@(negedge wb_clk_i);
		if (wbs_ack_o || !hb_csn_o || hb_clk_o || hb_dq_oe_o || hb_rwds_oe_o || hb_rstn_o) begin
			$display("outputs are not inactive during reset");
			abort_run();
		end
		@(posedge wb_clk_i);
		arst_n_i <= 1'b1;
		@(negedge wb_clk_i);
		if (hb_rstn_o) begin
			$display("device reset released in the same cycle as the bus reset");
			abort_run();
		end
		@(negedge wb_clk_i);
		if (!hb_rstn_o) begin
			$display("device reset still low one cycle after the bus reset");
			abort_run();
		end
		fd = $fopen("bench/hbus_input.dat", "r");
		if (fd == 0) begin
			$display("cannot open bench/hbus_input.dat");
			abort_run();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 8 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h", name, op, addr, data, sel, dly, expv);
			if (n != 7) begin
				$display("malformed stimulus line: %0s", line);
				abort_run();
			end
			run_step(name, op, addr, data, sel, dly, expv);
			steps++;
		end
		$fclose(fd);
		if (steps == 0) begin
			$display("no test steps found in the stimulus file");
			abort_run();
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

//--- bench/wb_hbus_props.sv
`timescale 1ns/1ps

module wb_hbus_props (
	input logic wb_clk_i,
	input logic arst_n_i,
	input logic wbs_stb_i,
	input logic wbs_cyc_i,
	input logic wbs_ack_o,
	input logic hb_csn_o,
	input logic hb_clk_o,
	input logic hb_dq_oe_o
);

	logic seen_req;

	// set by the first bus request after reset
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			seen_req <= 1'b0;
		else if (wbs_stb_i && wbs_cyc_i)
			seen_req <= 1'b1;
	end

	ack_needs_strobe: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		wbs_ack_o |-> (wbs_stb_i && wbs_cyc_i))
		else $error("acknowledge without strobe and cycle");

	dq_oe_needs_cs: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		hb_dq_oe_o |-> !hb_csn_o)
		else $error("data output enabled while chip select is high");

	clk_quiet_when_deselected: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		hb_csn_o |-> $stable(hb_clk_o))
		else $error("link clock toggled while chip select is high");

	cs_high_until_request: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		!seen_req |-> hb_csn_o)
		else $error("chip select went low before any request");

endmodule

bind wb_hbus_top wb_hbus_props u_props (
	.wb_clk_i   (wb_clk_i),
	.arst_n_i   (arst_n_i),
	.wbs_stb_i  (wbs_stb_i),
	.wbs_cyc_i  (wbs_cyc_i),
	.wbs_ack_o  (wbs_ack_o),
	.hb_csn_o   (hb_csn_o),
	.hb_clk_o   (hb_clk_o),
	.hb_dq_oe_o (hb_dq_oe_o)
);

//--- build.f
hw/hbus_pkg.sv
hw/wb_addr_decode.sv
hw/hbus_csr_bank.sv
hw/hbus_sequencer.sv
hw/wb_resp_mux.sv
hw/wb_hbus_top.sv
bench/wb_hbus_props.sv
bench/tb_wb_hbus.sv

//--- hw/hbus_csr_bank.sv
`timescale 1ns/1ps

module hbus_csr_bank import hbus_pkg::*; (
	input  logic       wb_clk_i,
	input  logic       arst_n_i,
	input  hb_req_t    req_i,
	output hb_timing_t timing_o
);

	logic [5:0] latency_r;
	logic [7:0] timing_r;
	logic [3:0] tcsh_r;
	logic [4:0] trmax_r;
	logic       csr_wr;

	// one write per access, low byte lane must be enabled
	assign csr_wr = (req_i.region == REGION_CSR) && req_i.first &&
		req_i.we && req_i.sel[0];

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			latency_r <= LATENCY_RST;
			timing_r  <= TIMING_RST;
			tcsh_r    <= TCSH_RST;
			trmax_r   <= TRMAX_RST;
		end else if (csr_wr) begin
			case (req_i.csr_sel)
				CSR_SEL_LATENCY: begin
					latency_r <= req_i.wdata[5:0];
				end
				CSR_SEL_TIMING: begin
					timing_r <= req_i.wdata[7:0];
				end
				CSR_SEL_TCSH: begin
					tcsh_r <= req_i.wdata[3:0];
				end
				CSR_SEL_TRMAX: begin
					trmax_r <= req_i.wdata[4:0];
				end
				// status is read only
				default: begin
				end
			endcase
		end
	end

	// latency register is {fixed, double, tacc}
	assign timing_o.fixed_latency  = latency_r[5];
	assign timing_o.double_latency = latency_r[4];
	assign timing_o.tacc           = latency_r[3:0];

	// timing register is {tpre, tpost}
	assign timing_o.tpre  = timing_r[7:4];
	assign timing_o.tpost = timing_r[3:0];

	assign timing_o.tcsh  = tcsh_r;
	assign timing_o.trmax = trmax_r;
	assign timing_o.spare = 3'b000;

endmodule

//--- hw/hbus_pkg.sv
package hbus_pkg;

	// address window, RAM first, then device registers and local CSRs
	localparam logic [31:0] BASE_ADDR    = 32'h3000_0000;
	localparam logic [31:0] RAM_MASK     = 32'hff80_0000;
	localparam logic [31:0] REG_CSR_MASK = 32'hffc0_0000;
	localparam logic [31:0] REG_BASE     = BASE_ADDR + 32'h0080_0000;
	localparam logic [31:0] CSR_BASE     = BASE_ADDR + 32'h00c0_0000;

	// byte offsets inside the CSR block
	localparam logic [31:0] CSR_LATENCY_OFS = 32'd0;
	localparam logic [31:0] CSR_TIMING_OFS  = 32'd4;
	localparam logic [31:0] CSR_TCSH_OFS    = 32'd8;
	localparam logic [31:0] CSR_TRMAX_OFS   = 32'd12;
	localparam logic [31:0] CSR_STATUS_OFS  = 32'd16;

	// {fixed, double, tacc}
	localparam logic [5:0] LATENCY_RST = 6'h36;
	// {tpre, tpost}
	localparam logic [7:0] TIMING_RST  = 8'h44;
	localparam logic [3:0] TCSH_RST    = 4'h4;
	localparam logic [4:0] TRMAX_RST   = 5'h14;

	localparam int CA_BYTES   = 6;
	localparam int DATA_BYTES = 4;

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_RAM,
		REGION_REG,
		REGION_CSR
	} region_e;

	typedef enum logic [2:0] {
		CSR_SEL_LATENCY,
		CSR_SEL_TIMING,
		CSR_SEL_TCSH,
		CSR_SEL_TRMAX,
		CSR_SEL_STATUS,
		CSR_SEL_NONE
	} csr_sel_e;

	typedef struct packed {
		region_e     region;
		csr_sel_e    csr_sel;
		logic        first;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] wdata;
		// region offset in 16-bit words
		logic [30:0] waddr;
	} hb_req_t;

	typedef struct packed {
		logic       fixed_latency;
		logic       double_latency;
		logic [3:0] tacc;
		logic [3:0] tpre;
		logic [3:0] tpost;
		logic [3:0] tcsh;
		logic [4:0] trmax;
		logic [2:0] spare;
	} hb_timing_t;

	typedef struct packed {
		logic        rd;
		logic        reg_space;
		logic        linear;
		logic [28:0] addr_hi;
		logic [12:0] rsvd;
		logic [2:0]  addr_lo;
	} hb_ca_fields_t;

	// command-address word, built by field and sent byte by byte
	typedef union packed {
		hb_ca_fields_t               f;
		logic [CA_BYTES-1:0][7:0]    bytes;
	} hb_ca_u;

endpackage

//--- hw/hbus_sequencer.sv
`timescale 1ns/1ps

module hbus_sequencer import hbus_pkg::*; (
	input  logic        wb_clk_i,
	input  logic        arst_n_i,
	input  hb_req_t     req_i,
	input  hb_timing_t  timing_i,
	input  logic        hb_rwds_i,
	input  logic [7:0]  hb_dq_i,
	output logic        ready_o,
	output logic [31:0] rdata_o,
	output logic        read_timeout_o,
	output logic        hb_rstn_o,
	output logic        hb_csn_o,
	output logic        hb_clk_o,
	output logic        hb_clkn_o,
	output logic        hb_rwds_o,
	output logic        hb_rwds_oe_o,
	output logic [7:0]  hb_dq_o,
	output logic        hb_dq_oe_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PRE,
		ST_CA,
		ST_LAT,
		ST_DATA,
		ST_POST,
		ST_HOLD
	} seq_state_e;

	seq_state_e  state;
	logic [5:0]  cnt;
	logic [1:0]  rd_idx;
	logic        armed;
	logic        rwds_seen;
	logic        ready_r;
	logic        timeout_r;
	logic        rstn_r;
	logic        we_q;
	logic [3:0]  sel_q;
	logic [31:0] wdata_q;
	logic [31:0] rdata_q;
	hb_ca_u      ca_d;
	hb_ca_u      ca_q;
	logic        req_hit;
	logic        start;
	logic        dbl;
	logic        skip_lat;
	logic        wr_phase;
	logic [5:0]  lat_len;
	logic [5:0]  data_cnt;
	logic [1:0]  wr_byte;
	logic [1:0]  rd_byte;

	assign req_hit = (req_i.region == REGION_RAM) || (req_i.region == REGION_REG);
	// armed again only once the previous request has gone away
	assign start = (state == ST_IDLE) && armed && req_hit;

	always_comb begin
		ca_d.f.rd        = ~req_i.we;
		ca_d.f.reg_space = (req_i.region == REGION_REG);
		ca_d.f.linear    = 1'b1;
		ca_d.f.addr_hi   = {1'b0, req_i.waddr[30:3]};
		ca_d.f.rsvd      = '0;
		ca_d.f.addr_lo   = req_i.waddr[2:0];
	end

	// device asks for double latency by RWDS high during CA
	assign dbl = timing_i.double_latency ||
		(!timing_i.fixed_latency && (rwds_seen || hb_rwds_i));
	assign lat_len = dbl ? {timing_i.tacc, 2'b00} : {1'b0, timing_i.tacc, 1'b0};
	// register writes go straight to data
	assign skip_lat = (we_q && ca_q.f.reg_space) || (lat_len == 6'd0);
	assign data_cnt = we_q ? 6'(DATA_BYTES - 1) : {1'b0, timing_i.trmax};

	// byte order on the link is 15:8, 7:0, 31:24, 23:16
	assign wr_byte = {~cnt[1], cnt[0]};
	assign rd_byte = {rd_idx[1], ~rd_idx[0]};

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= ST_IDLE;
			cnt       <= '0;
			rd_idx    <= '0;
			armed     <= 1'b1;
			rwds_seen <= 1'b0;
			ready_r   <= 1'b0;
			timeout_r <= 1'b0;
		end else begin
			ready_r <= 1'b0;
			if (!req_hit)
				armed <= 1'b1;
			case (state)
				ST_IDLE: begin
					if (start) begin
						armed     <= 1'b0;
						rwds_seen <= 1'b0;
						cnt       <= {2'b00, timing_i.tpre};
						state     <= ST_PRE;
					end
				end
				ST_PRE: begin
					if (cnt <= 6'd1) begin
						cnt   <= 6'(CA_BYTES - 1);
						state <= ST_CA;
					end else begin
						cnt <= cnt - 6'd1;
					end
				end
				ST_CA: begin
					rwds_seen <= rwds_seen | hb_rwds_i;
					if (cnt == 6'd0) begin
						rd_idx <= '0;
						if (skip_lat) begin
							cnt   <= data_cnt;
							state <= ST_DATA;
						end else begin
							cnt   <= lat_len;
							state <= ST_LAT;
						end
					end else begin
						cnt <= cnt - 6'd1;
					end
				end
				ST_LAT: begin
					if (cnt <= 6'd1) begin
						cnt   <= data_cnt;
						state <= ST_DATA;
					end else begin
						cnt <= cnt - 6'd1;
					end
				end
				ST_DATA: begin
					if (we_q) begin
						if (cnt == 6'd0) begin
							cnt   <= {2'b00, timing_i.tpost};
							state <= ST_POST;
						end else begin
							cnt <= cnt - 6'd1;
						end
					end else if (hb_rwds_i) begin
						// each captured byte restarts the timeout
						rd_idx <= rd_idx + 2'd1;
						cnt    <= {1'b0, timing_i.trmax};
						if (rd_idx == 2'd3) begin
							timeout_r <= 1'b0;
							cnt       <= {2'b00, timing_i.tpost};
							state     <= ST_POST;
						end
					end else if (cnt <= 6'd1) begin
						timeout_r <= 1'b1;
						cnt       <= {2'b00, timing_i.tpost};
						state     <= ST_POST;
					end else begin
						cnt <= cnt - 6'd1;
					end
				end
				ST_POST: begin
					if (cnt <= 6'd1) begin
						// no ready for a request the master gave up on
						ready_r <= !armed && req_hit;
						cnt     <= {2'b00, timing_i.tcsh};
						state   <= ST_HOLD;
					end else begin
						cnt <= cnt - 6'd1;
					end
				end
				ST_HOLD: begin
					if (cnt <= 6'd1)
						state <= ST_IDLE;
					else
						cnt <= cnt - 6'd1;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (start) begin
			we_q    <= req_i.we;
			sel_q   <= req_i.sel;
			wdata_q <= req_i.wdata;
			ca_q    <= ca_d;
		end
		if ((state == ST_DATA) && !we_q) begin
			if (hb_rwds_i)
				rdata_q[rd_byte*8 +: 8] <= hb_dq_i;
			else if (cnt <= 6'd1)
				rdata_q <= '0;
		end
	end

	// device reset released one cycle after ours
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			rstn_r <= 1'b0;
		else
			rstn_r <= 1'b1;
	end

	assign wr_phase = (state == ST_DATA) && we_q;

	assign hb_rstn_o    = rstn_r;
	assign hb_csn_o     = (state == ST_IDLE) || (state == ST_HOLD);
	// one toggle per byte, ends low after an even count
	assign hb_clk_o     = ((state == ST_CA) || wr_phase) ? cnt[0] : 1'b0;
	assign hb_clkn_o    = ~hb_clk_o;
	assign hb_dq_oe_o   = (state == ST_CA) || wr_phase;
	assign hb_rwds_oe_o = wr_phase;
	assign hb_rwds_o    = wr_phase ? ~sel_q[wr_byte] : 1'b0;

	always_comb begin
		if (state == ST_CA)
			hb_dq_o = ca_q.bytes[cnt[2:0]];
		else if (wr_phase)
			hb_dq_o = wdata_q[wr_byte*8 +: 8];
		else
			hb_dq_o = 8'h00;
	end

	assign ready_o        = ready_r;
	assign rdata_o        = rdata_q;
	assign read_timeout_o = timeout_r;

endmodule

//--- hw/wb_addr_decode.sv
`timescale 1ns/1ps

module wb_addr_decode import hbus_pkg::*; (
	input  logic        wb_clk_i,
	input  logic        arst_n_i,
	input  logic        wbs_stb_i,
	input  logic        wbs_cyc_i,
	input  logic        wbs_we_i,
	input  logic [3:0]  wbs_sel_i,
	input  logic [31:0] wbs_dat_i,
	input  logic [31:0] wbs_adr_i,
	output hb_req_t     req_o
);

	region_e     region;
	region_e     prev_region;
	csr_sel_e    csr_sel;
	logic [31:0] offset;
	logic        valid;

	assign valid = wbs_stb_i && wbs_cyc_i;

	always_comb begin
		if (!valid)
			region = REGION_NONE;
		else if ((wbs_adr_i & RAM_MASK) == BASE_ADDR)
			region = REGION_RAM;
		else if ((wbs_adr_i & REG_CSR_MASK) == REG_BASE)
			region = REGION_REG;
		else if ((wbs_adr_i & REG_CSR_MASK) == CSR_BASE)
			region = REGION_CSR;
		else
			region = REGION_NONE;
	end

	always_comb begin
		case (region)
			REGION_RAM:             offset = wbs_adr_i & ~RAM_MASK;
			REGION_REG, REGION_CSR: offset = wbs_adr_i & ~REG_CSR_MASK;
			default:                offset = '0;
		endcase
	end

	// only exact register addresses select a CSR
	always_comb begin
		csr_sel = CSR_SEL_NONE;
		if (region == REGION_CSR) begin
			case (wbs_adr_i)
				CSR_BASE + CSR_LATENCY_OFS: csr_sel = CSR_SEL_LATENCY;
				CSR_BASE + CSR_TIMING_OFS:  csr_sel = CSR_SEL_TIMING;
				CSR_BASE + CSR_TCSH_OFS:    csr_sel = CSR_SEL_TCSH;
				CSR_BASE + CSR_TRMAX_OFS:   csr_sel = CSR_SEL_TRMAX;
				CSR_BASE + CSR_STATUS_OFS:  csr_sel = CSR_SEL_STATUS;
				default:                    csr_sel = CSR_SEL_NONE;
			endcase
		end
	end

	// previous region marks the first cycle of a new access
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			prev_region <= REGION_NONE;
		else
			prev_region <= region;
	end

	assign req_o.region  = region;
	assign req_o.csr_sel = csr_sel;
	assign req_o.first   = (region != REGION_NONE) && (prev_region == REGION_NONE);
	assign req_o.we      = wbs_we_i;
	assign req_o.sel     = wbs_sel_i;
	assign req_o.wdata   = wbs_dat_i;
	assign req_o.waddr   = offset[31:1];

endmodule

//--- hw/wb_hbus_top.sv
`timescale 1ns/1ps

module wb_hbus_top import hbus_pkg::*; (
	input  logic        wb_clk_i,
	input  logic        arst_n_i,
	input  logic        wbs_stb_i,
	input  logic        wbs_cyc_i,
	input  logic        wbs_we_i,
	input  logic [3:0]  wbs_sel_i,
	input  logic [31:0] wbs_dat_i,
	input  logic [31:0] wbs_adr_i,
	output logic        wbs_ack_o,
	output logic [31:0] wbs_dat_o,
	output logic        hb_rstn_o,
	output logic        hb_csn_o,
	output logic        hb_clk_o,
	output logic        hb_clkn_o,
	output logic        hb_rwds_o,
	output logic        hb_rwds_oe_o,
	output logic [7:0]  hb_dq_o,
	output logic        hb_dq_oe_o,
	input  logic        hb_rwds_i,
	input  logic [7:0]  hb_dq_i
);

	hb_req_t     req;
	hb_timing_t  timing;
	logic        ready;
	logic        read_timeout;
	logic [31:0] rdata;

	wb_addr_decode u_decode (
		.wb_clk_i  (wb_clk_i),
		.arst_n_i  (arst_n_i),
		.wbs_stb_i (wbs_stb_i),
		.wbs_cyc_i (wbs_cyc_i),
		.wbs_we_i  (wbs_we_i),
		.wbs_sel_i (wbs_sel_i),
		.wbs_dat_i (wbs_dat_i),
		.wbs_adr_i (wbs_adr_i),
		.req_o     (req)
	);

	hbus_csr_bank u_csr (
		.wb_clk_i (wb_clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (req),
		.timing_o (timing)
	);

	hbus_sequencer u_seq (
		.wb_clk_i       (wb_clk_i),
		.arst_n_i       (arst_n_i),
		.req_i          (req),
		.timing_i       (timing),
		.hb_rwds_i      (hb_rwds_i),
		.hb_dq_i        (hb_dq_i),
		.ready_o        (ready),
		.rdata_o        (rdata),
		.read_timeout_o (read_timeout),
		.hb_rstn_o      (hb_rstn_o),
		.hb_csn_o       (hb_csn_o),
		.hb_clk_o       (hb_clk_o),
		.hb_clkn_o      (hb_clkn_o),
		.hb_rwds_o      (hb_rwds_o),
		.hb_rwds_oe_o   (hb_rwds_oe_o),
		.hb_dq_o        (hb_dq_o),
		.hb_dq_oe_o     (hb_dq_oe_o)
	);

	wb_resp_mux u_resp (
		.wb_clk_i       (wb_clk_i),
		.arst_n_i       (arst_n_i),
		.req_i          (req),
		.timing_i       (timing),
		.read_timeout_i (read_timeout),
		.ready_i        (ready),
		.rdata_i        (rdata),
		.wbs_ack_o      (wbs_ack_o),
		.wbs_dat_o      (wbs_dat_o)
	);

endmodule

//--- hw/wb_resp_mux.sv
`timescale 1ns/1ps

module wb_resp_mux import hbus_pkg::*; (
	input  logic        wb_clk_i,
	input  logic        arst_n_i,
	input  hb_req_t     req_i,
	input  hb_timing_t  timing_i,
	input  logic        read_timeout_i,
	input  logic        ready_i,
	input  logic [31:0] rdata_i,
	output logic        wbs_ack_o,
	output logic [31:0] wbs_dat_o
);

	logic        csr_hit;
	logic        hb_hit;
	logic        csr_ack_r;
	logic [31:0] csr_rdata;

	assign csr_hit = (req_i.region == REGION_CSR) && (req_i.csr_sel != CSR_SEL_NONE);
	assign hb_hit  = (req_i.region == REGION_RAM) || (req_i.region == REGION_REG);

	always_comb begin
		case (req_i.csr_sel)
			CSR_SEL_LATENCY: csr_rdata = {26'd0, timing_i.fixed_latency,
				timing_i.double_latency, timing_i.tacc};
			CSR_SEL_TIMING:  csr_rdata = {24'd0, timing_i.tpre, timing_i.tpost};
			CSR_SEL_TCSH:    csr_rdata = {28'd0, timing_i.tcsh};
			CSR_SEL_TRMAX:   csr_rdata = {27'd0, timing_i.trmax};
			CSR_SEL_STATUS:  csr_rdata = {31'd0, read_timeout_i};
			default:         csr_rdata = 32'd0;
		endcase
	end

	always_comb begin
		if (req_i.we)
			wbs_dat_o = 32'd0;
		else if (csr_hit)
			wbs_dat_o = csr_rdata;
		else if (hb_hit)
			wbs_dat_o = rdata_i;
		else
			wbs_dat_o = 32'd0;
	end

	// CSR ack one cycle late, held while the strobe stays
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			csr_ack_r <= 1'b0;
		else
			csr_ack_r <= csr_hit;
	end

	// unmapped addresses are never acknowledged
	assign wbs_ack_o = hb_hit ? ready_i : (csr_hit && csr_ack_r);

endmodule
